// File: Makefile
TOP = tb_rf_2w4r
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f rf_2w4r.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f rf_2w4r.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: rf_2w4r.f
rf_geom_pkg.sv
rf_arch_pkg.sv
rf_bank_ram.sv
rf_live_table.sv
rf_read_port.sv
rf_2w4r.sv
tb_clock_gen.sv
rf_2w4r_checker.sv
tb_rf_2w4r.sv

// File: rf_2w4r.sv
`default_nettype none
`timescale 1ns/100ps

// Integer register file of the two issue core
// Two write ports, four read ports
// Each write port owns a bank with one RAM copy per read port, and the live
// value table picks the bank that holds the newest value of a register
module rf_2w4r #(
  parameter int data_width = rf_geom_pkg::default_data_width,
  parameter int reg_count = rf_geom_pkg::default_reg_count
) (
  input  wire                                          clka,
  input  wire                                          rst,
  input  wire  [data_width-1:0]                        pc0,
  input  wire  [data_width-1:0]                        pc1,
  input  wire                                          wr0,
  input  wire  [data_width/rf_geom_pkg::byte_bits-1:0] we0,
  input  wire  [$clog2(reg_count)-1:0]                 wa0,
  input  wire  [data_width-1:0]                        i0,
  input  wire                                          wr1,
  input  wire  [data_width/rf_geom_pkg::byte_bits-1:0] we1,
  input  wire  [$clog2(reg_count)-1:0]                 wa1,
  input  wire  [data_width-1:0]                        i1,
  input  wire  [$clog2(reg_count)-1:0]                 ra0,
  input  wire  [$clog2(reg_count)-1:0]                 ra1,
  input  wire  [$clog2(reg_count)-1:0]                 ra2,
  input  wire  [$clog2(reg_count)-1:0]                 ra3,
  output logic [data_width-1:0]                        o0,
  output logic [data_width-1:0]                        o1,
  output logic [data_width-1:0]                        o2,
  output logic [data_width-1:0]                        o3
);

  localparam int addr_w = $clog2(reg_count);
  localparam int lanes = data_width / rf_geom_pkg::byte_bits;
  localparam int num_writes = 2;
  localparam int num_reads = 4;
  localparam int num_slots = num_reads / rf_arch_pkg::ports_per_slot;

  // ========================================
  // Port bundling
  // ========================================

  // Loose ports are gathered into arrays so the instances can be generated
  logic                  wr_v   [num_writes];
  logic [lanes-1:0]      we_v   [num_writes];
  logic [addr_w-1:0]     wa_v   [num_writes];
  logic [data_width-1:0] i_v    [num_writes];
  logic [addr_w-1:0]     ra_v   [num_reads];
  logic [data_width-1:0] o_v    [num_reads];
  logic [data_width-1:0] pc_v   [num_slots];
  logic [data_width-1:0] bank_o [num_writes][num_reads];
  logic [reg_count-1:0]  live;

  assign wr_v[0] = wr0;
  assign wr_v[1] = wr1;
  assign we_v[0] = we0;
  assign we_v[1] = we1;
  assign wa_v[0] = wa0;
  assign wa_v[1] = wa1;
  assign i_v[0] = i0;
  assign i_v[1] = i1;

  assign ra_v[0] = ra0;
  assign ra_v[1] = ra1;
  assign ra_v[2] = ra2;
  assign ra_v[3] = ra3;

  assign o0 = o_v[0];
  assign o1 = o_v[1];
  assign o2 = o_v[2];
  assign o3 = o_v[3];

  assign pc_v[0] = pc0;
  assign pc_v[1] = pc1;

  // ========================================
  // RAM banks
  // ========================================

  // Bank k is written only by write port k
  // Copy n of each bank is read only by read port n
  for (genvar k = 0; k < num_writes; k++) begin : g_bank
    for (genvar n = 0; n < num_reads; n++) begin : g_copy
      rf_bank_ram #(
        .data_width (data_width),
        .reg_count  (reg_count)
      ) u_ram (
        .clka (clka),
        .wr   (wr_v[k]),
        .we   (we_v[k]),
        .wa   (wa_v[k]),
        .i    (i_v[k]),
        .ra   (ra_v[n]),
        .o    (bank_o[k][n])
      );
    end
  end

  // ========================================
  // Live value table
  // ========================================

  rf_live_table #(
    .reg_count (reg_count)
  ) u_live (
    .clka (clka),
    .rst  (rst),
    .wr0  (wr0),
    .wa0  (wa0),
    .wr1  (wr1),
    .wa1  (wa1),
    .live (live)
  );

  // ========================================
  // Read ports
  // ========================================

  // The slot of port n is n / ports_per_slot and selects pc0 or pc1
  for (genvar n = 0; n < num_reads; n++) begin : g_read
    rf_read_port #(
      .data_width (data_width),
      .reg_count  (reg_count)
    ) u_port (
      .ra    (ra_v[n]),
      .pc    (pc_v[n / rf_arch_pkg::ports_per_slot]),
      .live  (live),
      .wr0   (wr0),
      .wa0   (wa0),
      .i0    (i0),
      .wr1   (wr1),
      .wa1   (wa1),
      .i1    (i1),
      .bank0 (bank_o[0][n]),
      .bank1 (bank_o[1][n]),
      .o     (o_v[n])
    );
  end

endmodule : rf_2w4r

`default_nettype wire

// File: rf_2w4r_checker.sv
`default_nettype none
`timescale 1ns/100ps

// Port level assertions, bound into rf_2w4r
module rf_2w4r_checker #(
  parameter int data_width = 64,
  parameter int reg_count = 64
) (
  input wire                         clka,
  input wire                         rst,
  input wire                         wr0,
  input wire [$clog2(reg_count)-1:0] wa0,
  input wire                         wr1,
  input wire [$clog2(reg_count)-1:0] wa1,
  input wire [data_width-1:0]        i1,
  input wire [$clog2(reg_count)-1:0] ra0,
  input wire [$clog2(reg_count)-1:0] ra1,
  input wire [$clog2(reg_count)-1:0] ra2,
  input wire [$clog2(reg_count)-1:0] ra3,
  input wire [data_width-1:0]        o0,
  input wire [data_width-1:0]        o1,
  input wire [data_width-1:0]        o2,
  input wire [data_width-1:0]        o3
);

  localparam int addr_w = $clog2(reg_count);
  localparam logic [addr_w-1:0] zero_a = addr_w'(rf_arch_pkg::zero_reg);
  localparam logic [addr_w-1:0] pc_a = addr_w'(rf_arch_pkg::pc_alias_reg);

  logic coll;
  int fail_count = 0;

  // Both write ports on one ordinary register in the same cycle
  assign coll = wr0 && wr1 && (wa0 == wa1) && (wa1 != zero_a) && (wa1 != pc_a);

  // ========================================
  // Zero register
  // ========================================

  a_zero0: assert property (@(posedge clka) disable iff (rst) (ra0 == zero_a) |-> (o0 == '0))
    else begin
      $error("o0 not zero for the zero register");
      fail_count++;
    end
  a_zero1: assert property (@(posedge clka) disable iff (rst) (ra1 == zero_a) |-> (o1 == '0))
    else begin
      $error("o1 not zero for the zero register");
      fail_count++;
    end
  a_zero2: assert property (@(posedge clka) disable iff (rst) (ra2 == zero_a) |-> (o2 == '0))
    else begin
      $error("o2 not zero for the zero register");
      fail_count++;
    end
  a_zero3: assert property (@(posedge clka) disable iff (rst) (ra3 == zero_a) |-> (o3 == '0))
    else begin
      $error("o3 not zero for the zero register");
      fail_count++;
    end

  // ========================================
  // Write collision forwarding
  // ========================================

  a_coll0: assert property (@(posedge clka) disable iff (rst) (coll && ra0 == wa1) |-> (o0 == i1))
    else begin
      $error("o0 did not forward port 1 on a collision");
      fail_count++;
    end
  a_coll1: assert property (@(posedge clka) disable iff (rst) (coll && ra1 == wa1) |-> (o1 == i1))
    else begin
      $error("o1 did not forward port 1 on a collision");
      fail_count++;
    end
  a_coll2: assert property (@(posedge clka) disable iff (rst) (coll && ra2 == wa1) |-> (o2 == i1))
    else begin
      $error("o2 did not forward port 1 on a collision");
      fail_count++;
    end
  a_coll3: assert property (@(posedge clka) disable iff (rst) (coll && ra3 == wa1) |-> (o3 == i1))
    else begin
      $error("o3 did not forward port 1 on a collision");
      fail_count++;
    end

endmodule : rf_2w4r_checker

`default_nettype wire

// File: rf_arch_pkg.sv
`default_nettype none

// ========================================
// Architectural register map
// ========================================

package rf_arch_pkg;

  // Hardwired zero register, writes to it are stored but never seen
  parameter int zero_reg = 0;

  // Reads of this register return the program counter of the issue slot
  // that owns the read port
  parameter int pc_alias_reg = 53;

  // ========================================
  // Read port to issue slot mapping
  // ========================================

  // Read ports are grouped in order, so ports 0 and 1 serve slot 0 and
  // ports 2 and 3 serve slot 1
  parameter int ports_per_slot = 2;

endpackage : rf_arch_pkg

`default_nettype wire

// File: rf_bank_ram.sv
`default_nettype none
`timescale 1ns/100ps

// One copy of a write bank
// Every read port has its own copy so each copy needs only one read address
module rf_bank_ram #(
  parameter int data_width = 64,
  parameter int reg_count = 64
) (
  input  wire                                          clka,
  input  wire                                          wr,
  input  wire  [data_width/rf_geom_pkg::byte_bits-1:0] we,
  input  wire  [$clog2(reg_count)-1:0]                 wa,
  input  wire  [data_width-1:0]                        i,
  input  wire  [$clog2(reg_count)-1:0]                 ra,
  output logic [data_width-1:0]                        o
);

  localparam int lanes = data_width / rf_geom_pkg::byte_bits;
  localparam int lane_w = rf_geom_pkg::byte_bits;

  // Distributed RAM, contents come up as zero at configuration
  logic [data_width-1:0] mem [reg_count] = '{default: '0};

  // ========================================
  // Write side
  // ========================================

  // Only the enabled lanes are updated, the rest of the word keeps
  // whatever this bank held before
  always_ff @(posedge clka) begin
    if (wr) begin
      for (int b = 0; b < lanes; b++) begin
        if (we[b]) begin
          mem[wa][b*lane_w +: lane_w] <= i[b*lane_w +: lane_w];
        end
      end
    end
  end

  // ========================================
  // Read side
  // ========================================

  // Asynchronous read, a write becomes visible here one cycle after its edge
  assign o = mem[ra];

endmodule : rf_bank_ram

`default_nettype wire

// File: rf_geom_pkg.sv
`default_nettype none

// ========================================
// Register file geometry
// ========================================

package rf_geom_pkg;

  // Width of one architectural register in bits
  parameter int default_data_width = 64;

  // Number of architectural registers held in each RAM copy
  parameter int default_reg_count = 64;

  // ========================================
  // Byte lanes
  // ========================================

  // One write enable covers this many data bits
  // The lane count of a port is data_width / byte_bits, so data_width
  // has to be a whole multiple of it
  parameter int byte_bits = 8;

endpackage : rf_geom_pkg

`default_nettype wire

// File: rf_live_table.sv
`default_nettype none
`timescale 1ns/100ps

// Live value table
// One bit per register tells which write bank holds the newest value,
// 0 for bank 0 and 1 for bank 1
module rf_live_table #(
  parameter int reg_count = 64
) (
  input  wire                          clka,
  input  wire                          rst,
  input  wire                          wr0,
  input  wire  [$clog2(reg_count)-1:0] wa0,
  input  wire                          wr1,
  input  wire  [$clog2(reg_count)-1:0] wa1,
  output logic [reg_count-1:0]         live
);

  localparam int addr_w = $clog2(reg_count);

  logic [reg_count-1:0] live_nxt;

  // ========================================
  // Next state
  // ========================================

  // Port 1 is checked first so it wins when both ports hit the same register
  // In that case bank 0 still stores port 0's data, but nobody reads it
  always_comb begin
    live_nxt = live;
    for (int r = 0; r < reg_count; r++) begin
      if (wr1 && (wa1 == addr_w'(r))) begin
        live_nxt[r] = 1'b1;
      end else if (wr0 && (wa0 == addr_w'(r))) begin
        live_nxt[r] = 1'b0;
      end
    end
  end

  // ========================================
  // State
  // ========================================

  // After reset every register is served from bank 0
  always_ff @(posedge clka or posedge rst) begin
    if (rst) begin
      live <= '0;
    end else begin
      live <= live_nxt;
    end
  end

endmodule : rf_live_table

`default_nettype wire

// File: rf_read_port.sv
`default_nettype none
`timescale 1ns/100ps

// Read selection for one port
// Everything here is combinational, so the data leaves in the same cycle
// the address arrives
module rf_read_port #(
  parameter int data_width = 64,
  parameter int reg_count = 64
) (
  input  wire  [$clog2(reg_count)-1:0] ra,
  input  wire  [data_width-1:0]        pc,
  input  wire  [reg_count-1:0]         live,
  input  wire                          wr0,
  input  wire  [$clog2(reg_count)-1:0] wa0,
  input  wire  [data_width-1:0]        i0,
  input  wire                          wr1,
  input  wire  [$clog2(reg_count)-1:0] wa1,
  input  wire  [data_width-1:0]        i1,
  input  wire  [data_width-1:0]        bank0,
  input  wire  [data_width-1:0]        bank1,
  output logic [data_width-1:0]        o
);

  localparam int addr_w = $clog2(reg_count);

  // Special register numbers at the width of the address
  localparam logic [addr_w-1:0] zero_addr = addr_w'(rf_arch_pkg::zero_reg);
  localparam logic [addr_w-1:0] pc_addr = addr_w'(rf_arch_pkg::pc_alias_reg);

  logic hit1;
  logic hit0;

  // A same cycle write to the addressed register
  assign hit1 = wr1 && (wa1 == ra);
  assign hit0 = wr0 && (wa0 == ra);

  // ========================================
  // Priority chain
  // ========================================

  // Forwarding hands back the whole write word, byte enables are ignored
  // on this path because the next read after the edge comes from the bank
  always_comb begin
    if (ra == zero_addr) begin
      o = '0;
    end else if (ra == pc_addr) begin
      o = pc;
    end else if (hit1) begin
      o = i1;
    end else if (hit0) begin
      o = i0;
    end else if (live[ra]) begin
      o = bank1;
    end else begin
      o = bank0;
    end
  end

endmodule : rf_read_port

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

// Testbench clock and reset, reset held for four rising edges
module tb_clock_gen #(
  parameter int period_ns = 4
) (
  output logic clka,
  output logic rst
);

  initial begin
    clka = 1'b0;
    forever #(period_ns / 2) clka = ~clka;
  end

  // Release on a falling edge so the first active edge is clean
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clka);
    @(negedge clka);
    rst = 1'b0;
  end

endmodule : tb_clock_gen

`default_nettype wire

// File: tb_rf_2w4r.sv
`default_nettype none
`timescale 1ns/100ps

module tb_rf_2w4r;

  localparam int dw = rf_geom_pkg::default_data_width;
  localparam int rc = rf_geom_pkg::default_reg_count;
  localparam int aw = $clog2(rc);
  localparam int bb = rf_geom_pkg::byte_bits;
  localparam int lanes = dw / bb;
  localparam int clk_period = 4;
  localparam int random_rows = 200;
  localparam int max_rows = 240;
  localparam int timeout_ns = (max_rows + 4 + 40) * clk_period;

  // One table row is one clock cycle of stimulus
  // With chk set the reads are checked in the row's own cycle, with chk clear
  // they are checked in an idle cycle after the row's write edge
  typedef struct packed {
    logic [3:0]            test;
    logic                  chk;
    logic                  wr0;
    logic [lanes-1:0]      we0;
    logic [aw-1:0]         wa0;
    logic [dw-1:0]         i0;
    logic                  wr1;
    logic [lanes-1:0]      we1;
    logic [aw-1:0]         wa1;
    logic [dw-1:0]         i1;
    logic [3:0][aw-1:0]    ra;
    logic [dw-1:0]         pc0;
    logic [dw-1:0]         pc1;
  } row_t;

  logic clka;
  logic rst;
  logic [dw-1:0] pc0;
  logic [dw-1:0] pc1;
  logic wr0;
  logic [lanes-1:0] we0;
  logic [aw-1:0] wa0;
  logic [dw-1:0] i0;
  logic wr1;
  logic [lanes-1:0] we1;
  logic [aw-1:0] wa1;
  logic [dw-1:0] i1;
  logic [aw-1:0] ra0;
  logic [aw-1:0] ra1;
  logic [aw-1:0] ra2;
  logic [aw-1:0] ra3;
  logic [dw-1:0] o0;
  logic [dw-1:0] o1;
  logic [dw-1:0] o2;
  logic [dw-1:0] o3;

  row_t rows [max_rows];
  int row_count = 0;
  int errors = 0;
  int test_errors = 0;
  int checks = 0;
  logic [31:0] lfsr_state = 32'd94318;

  // Shadow model of both banks and the live table
  logic [dw-1:0] sh_bank0 [rc];
  logic [dw-1:0] sh_bank1 [rc];
  logic [rc-1:0] sh_live;

  string test_name [7] = '{"", "reset and zero register", "pc alias",
                           "write then read", "forwarding and collision",
                           "byte enables and bank switch", "random traffic"};

  tb_clock_gen #(.period_ns(clk_period)) u_clk (.clka(clka), .rst(rst));

  rf_2w4r dut (
    .clka (clka), .rst (rst), .pc0 (pc0), .pc1 (pc1),
    .wr0  (wr0), .we0 (we0), .wa0 (wa0), .i0 (i0),
    .wr1  (wr1), .we1 (we1), .wa1 (wa1), .i1 (i1),
    .ra0  (ra0), .ra1 (ra1), .ra2 (ra2), .ra3 (ra3),
    .o0   (o0), .o1 (o1), .o2 (o2), .o3 (o3)
  );

  bind rf_2w4r rf_2w4r_checker #(.data_width(data_width), .reg_count(reg_count)) u_checker (.*);

  // ========================================
  // Random numbers
  // ========================================

  // Galois LFSR with taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // ========================================
  // Stimulus table
  // ========================================

  task automatic add_row(input int test, input logic chk,
                         input logic w0, input logic [lanes-1:0] e0, input int a0,
                         input logic [dw-1:0] d0,
                         input logic w1, input logic [lanes-1:0] e1, input int a1,
                         input logic [dw-1:0] d1,
                         input int r0, input int r1, input int r2, input int r3,
                         input logic [dw-1:0] p0, input logic [dw-1:0] p1);
    row_t row;
    row.test = 4'(test);
    row.chk = chk;
    row.wr0 = w0;
    row.we0 = e0;
    row.wa0 = aw'(a0);
    row.i0 = d0;
    row.wr1 = w1;
    row.we1 = e1;
    row.wa1 = aw'(a1);
    row.i1 = d1;
    row.ra[0] = aw'(r0);
    row.ra[1] = aw'(r1);
    row.ra[2] = aw'(r2);
    row.ra[3] = aw'(r3);
    row.pc0 = p0;
    row.pc1 = p1;
    rows[row_count] = row;
    row_count++;
  endtask

  task automatic add_random_row();
    logic [63:0] w0;
    logic [63:0] e0;
    logic [63:0] a0;
    logic [63:0] d0;
    logic [63:0] w1;
    logic [63:0] e1;
    logic [63:0] a1;
    logic [63:0] d1;
    logic [63:0] r [4];
    logic [63:0] p0;
    logic [63:0] p1;
    w0 = rand_bits(1);
    e0 = rand_bits(lanes);
    a0 = rand_bits(aw);
    d0 = rand_bits(dw);
    w1 = rand_bits(1);
    e1 = rand_bits(lanes);
    a1 = rand_bits(aw);
    d1 = rand_bits(dw);
    for (int n = 0; n < 4; n++) begin
      r[n] = rand_bits(aw);
    end
    p0 = rand_bits(dw);
    p1 = rand_bits(dw);
    add_row(6, 1'b1, w0[0], e0[lanes-1:0], int'(a0[aw-1:0]), d0,
            w1[0], e1[lanes-1:0], int'(a1[aw-1:0]), d1,
            int'(r[0][aw-1:0]), int'(r[1][aw-1:0]), int'(r[2][aw-1:0]),
            int'(r[3][aw-1:0]), p0, p1);
  endtask

  task automatic build_table();
    logic [dw-1:0] pa;
    logic [dw-1:0] pb;
    pa = 64'h0000_1000_0000_0040;
    pb = 64'h0000_2000_0000_0080;
    // Reset state and the zero register
    add_row(1, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 1, 2, 3, 4, '0, '0);
    add_row(1, 1, 1, 8'hFF, 0, 64'hDEAD_BEEF_0000_1111, 1, 8'hFF, 0,
            64'hCAFE_F00D_2222_3333, 0, 0, 0, 0, '0, '0);
    add_row(1, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 0, 0, 0, 0, '0, '0);
    add_row(1, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 1, 2, 3, 4, '0, '0);
    // Program counter alias
    add_row(2, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 53, 53, 53, 53, pa, pb);
    add_row(2, 1, 1, 8'hFF, 53, 64'h1111_2222_3333_4444, 1, 8'hFF, 53,
            64'h5555_6666_7777_8888, 53, 53, 53, 53, pa, pb);
    add_row(2, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 53, 53, 53, 53, pb, pa);
    // Write then read through both banks
    add_row(3, 0, 1, 8'hFF, 5, 64'hA5A5_0101_0202_0303, 1, 8'hFF, 6,
            64'h5A5A_0404_0505_0606, 5, 6, 5, 6, pa, pb);
    add_row(3, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 5, 6, 6, 5, pa, pb);
    add_row(3, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 6, 5, 5, 6, pa, pb);
    // Forwarding with a collision on register 10
    add_row(4, 1, 1, 8'hFF, 10, 64'h0C0C_0C0C_0C0C_0C0C, 1, 8'hFF, 10,
            64'h0D0D_0D0D_0D0D_0D0D, 10, 10, 10, 10, pa, pb);
    add_row(4, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 10, 10, 10, 10, pa, pb);
    add_row(4, 1, 1, 8'hFF, 11, 64'h0E0E_1234_5678_0E0E, 0, 8'h00, 0, '0,
            11, 10, 11, 10, pa, pb);
    add_row(4, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 11, 11, 10, 11, pa, pb);
    // Partial writes that move register 20 between the banks
    add_row(5, 1, 1, 8'hFF, 20, 64'h1122_3344_5566_7788, 0, 8'h00, 0, '0,
            20, 20, 20, 20, pa, pb);
    add_row(5, 1, 0, 8'h00, 0, '0, 1, 8'h0F, 20, 64'h99AA_BBCC_DDEE_FF00,
            20, 20, 20, 20, pa, pb);
    add_row(5, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 20, 20, 20, 20, pa, pb);
    add_row(5, 0, 1, 8'hF0, 20, 64'hF0E1_D2C3_B4A5_9687, 0, 8'h00, 0, '0,
            20, 5, 20, 6, pa, pb);
    add_row(5, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 20, 20, 20, 20, pa, pb);
    add_row(5, 1, 0, 8'h00, 0, '0, 1, 8'hC0, 20, 64'h7766_5544_3322_1100,
            20, 20, 20, 20, pa, pb);
    add_row(5, 1, 0, 8'h00, 0, '0, 0, 8'h00, 0, '0, 20, 20, 20, 20, pa, pb);
    for (int k = 0; k < random_rows; k++) begin
      add_random_row();
    end
  endtask

  // ========================================
  // Shadow model
  // ========================================

  function automatic logic [dw-1:0] expected_read(input row_t row, input int port);
    logic [aw-1:0] ra;
    ra = row.ra[port];
    if (ra == aw'(rf_arch_pkg::zero_reg)) begin
      return '0;
    end
    if (ra == aw'(rf_arch_pkg::pc_alias_reg)) begin
      return (port / rf_arch_pkg::ports_per_slot == 0) ? row.pc0 : row.pc1;
    end
    if (row.wr1 && row.wa1 == ra) begin
      return row.i1;
    end
    if (row.wr0 && row.wa0 == ra) begin
      return row.i0;
    end
    return sh_live[ra] ? sh_bank1[ra] : sh_bank0[ra];
  endfunction

  task automatic shadow_write(input row_t row);
    for (int b = 0; b < lanes; b++) begin
      if (row.wr0 && row.we0[b]) begin
        sh_bank0[row.wa0][b*bb +: bb] = row.i0[b*bb +: bb];
      end
      if (row.wr1 && row.we1[b]) begin
        sh_bank1[row.wa1][b*bb +: bb] = row.i1[b*bb +: bb];
      end
    end
    if (row.wr1) begin
      sh_live[row.wa1] = 1'b1;
    end
    if (row.wr0 && !(row.wr1 && row.wa1 == row.wa0)) begin
      sh_live[row.wa0] = 1'b0;
    end
  endtask

  task automatic check_value(input string name, input logic [dw-1:0] exp_v,
                             input logic [dw-1:0] act_v);
    checks++;
    if (act_v !== exp_v) begin
      $display("ERROR %s expected %h got %h", name, exp_v, act_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic check_reads(input row_t row);
    check_value("o0", expected_read(row, 0), o0);
    check_value("o1", expected_read(row, 1), o1);
    check_value("o2", expected_read(row, 2), o2);
    check_value("o3", expected_read(row, 3), o3);
  endtask

  // ========================================
  // Run
  // ========================================

  initial begin
    #(timeout_ns);
    $display("Watchdog expired before all table rows were applied");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    row_t idle;
    pc0 = '0;
    pc1 = '0;
    wr0 = 1'b0;
    we0 = '0;
    wa0 = '0;
    i0 = '0;
    wr1 = 1'b0;
    we1 = '0;
    wa1 = '0;
    i1 = '0;
    ra0 = '0;
    ra1 = '0;
    ra2 = '0;
    ra3 = '0;
    sh_live = '0;
    for (int r = 0; r < rc; r++) begin
      sh_bank0[r] = '0;
      sh_bank1[r] = '0;
    end
    build_table();
    @(negedge rst);
    @(posedge clka);
    for (int r = 0; r < row_count; r++) begin
      pc0 <= rows[r].pc0;
      pc1 <= rows[r].pc1;
      wr0 <= rows[r].wr0;
      we0 <= rows[r].we0;
      wa0 <= rows[r].wa0;
      i0 <= rows[r].i0;
      wr1 <= rows[r].wr1;
      we1 <= rows[r].we1;
      wa1 <= rows[r].wa1;
      i1 <= rows[r].i1;
      ra0 <= rows[r].ra[0];
      ra1 <= rows[r].ra[1];
      ra2 <= rows[r].ra[2];
      ra3 <= rows[r].ra[3];
      // Reads are combinational, so the middle of the cycle is stable
      @(negedge clka);
      if (rows[r].chk) begin
        check_reads(rows[r]);
      end
      @(posedge clka);
      shadow_write(rows[r]);
      if (!rows[r].chk) begin
        // The read addresses stay put for one cycle without writes, so the
        // reads come from the banks after the row's write edge
        idle = rows[r];
        idle.wr0 = 1'b0;
        idle.wr1 = 1'b0;
        wr0 <= 1'b0;
        wr1 <= 1'b0;
        @(negedge clka);
        check_reads(idle);
        @(posedge clka);
      end
      if (r == row_count - 1 || rows[r+1].test != rows[r].test) begin
        $display("test %0d %s: %0d errors", rows[r].test,
                 test_name[rows[r].test], test_errors);
        test_errors = 0;
      end
    end
    wr0 <= 1'b0;
    wr1 <= 1'b0;
    @(posedge clka);
    errors += dut.u_checker.fail_count;
    $display("rows %0d checks %0d errors %0d", row_count, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_rf_2w4r

`default_nettype wire
